//--- Makefile
# Verilator build and run for the bbox testbench
VERILATOR ?= verilator
TOP       ?= bbox_tb
FILELIST  ?= bbox.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard *.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bbox.f
raster_pkg.sv
bbox_minmax.sv
bbox_snap.sv
bbox_clip.sv
bbox_pipe.sv
bbox.sv
bbox_tb.sv
+incdir+.

//--- bbox.sv
// Bounding-box stage top level, one triangle per enabled edge, three edges of latency
`timescale 1ns/100ps

module bbox (
    input  logic                clk,
    input  logic                arst_n,
    input  raster_pkg::tri_t    in_tri,
    input  raster_pkg::rgb_t    in_color,
    input  logic                in_valid,
    input  raster_pkg::screen_t screen,
    input  raster_pkg::msaa_e   msaa,
    input  logic                halt_n,
    output raster_pkg::tri_t    out_tri,
    output raster_pkg::rgb_t    out_color,
    output raster_pkg::box_t    out_box,
    output logic                out_valid
);
    import raster_pkg::*;

    // Combinational front end, all at the input cycle
    box_t       raw_box;
    box_t       snap_box;
    box_t       clip_box;
    logic       clip_valid;

    // Pipeline ends
    bbox_item_t pipe_in;
    bbox_item_t pipe_out;

    bbox_minmax u_minmax (
        .clk      (clk),
        .arst_n   (arst_n),
        .triangle (in_tri),
        .raw_box  (raw_box)
    );

    bbox_snap u_snap (
        .clk      (clk),
        .arst_n   (arst_n),
        .raw_box  (raw_box),
        .msaa     (msaa),
        .snap_box (snap_box)
    );

    bbox_clip u_clip (
        .clk        (clk),
        .arst_n     (arst_n),
        .snap_box   (snap_box),
        .screen     (screen),
        .in_valid   (in_valid),
        .clip_box   (clip_box),
        .clip_valid (clip_valid)
    );

    // Triangle and colour ride unchanged beside the box
    assign pipe_in = '{triangle: in_tri, color: in_color, box: clip_box, valid: clip_valid};

    bbox_pipe u_pipe (
        .clk      (clk),
        .arst_n   (arst_n),
        .halt_n   (halt_n),
        .in_item  (pipe_in),
        .out_item (pipe_out)
    );

    assign out_tri   = pipe_out.triangle;
    assign out_color = pipe_out.color;
    assign out_box   = pipe_out.box;
    assign out_valid = pipe_out.valid;

endmodule

//--- bbox_clip.sv
// Clamps the snapped box to the screen and rejects boxes wholly off screen
`timescale 1ns/100ps

module bbox_clip (
    input  logic                clk,
    input  logic                arst_n,
    input  raster_pkg::box_t    snap_box,
    input  raster_pkg::screen_t screen,
    input  logic                in_valid,
    output raster_pkg::box_t    clip_box,
    output logic                clip_valid
);
    import raster_pkg::*;

    // Signed copies keep every compare below signed
    coord_t in_ll_x;
    coord_t in_ll_y;
    coord_t in_ur_x;
    coord_t in_ur_y;
    coord_t scr_w;
    coord_t scr_h;

    // Clamped corners
    coord_t ll_x;
    coord_t ll_y;
    coord_t ur_x;
    coord_t ur_y;

    assign in_ll_x = snap_box.ll_x;
    assign in_ll_y = snap_box.ll_y;
    assign in_ur_x = snap_box.ur_x;
    assign in_ur_y = snap_box.ur_y;
    assign scr_w   = screen.width;
    assign scr_h   = screen.height;

    // Lower left pulled up to the origin
    assign ll_x = (in_ll_x < 0) ? '0 : in_ll_x;
    assign ll_y = (in_ll_y < 0) ? '0 : in_ll_y;

    // Upper right pulled down to the screen edge
    assign ur_x = (in_ur_x > scr_w) ? scr_w : in_ur_x;
    assign ur_y = (in_ur_y > scr_h) ? scr_h : in_ur_y;

    assign clip_box.ll_x = ll_x;
    assign clip_box.ll_y = ll_y;
    assign clip_box.ur_x = ur_x;
    assign clip_box.ur_y = ur_y;

    // Reject when the box lies past any screen edge
    // ur still below zero means wholly left or below
    // ll still past the size means wholly right or above
    always_comb begin
        logic on_screen;
        on_screen = (ll_x <= scr_w) && (ur_x >= 0) &&
                    (ll_y <= scr_h) && (ur_y >= 0);
        clip_valid = in_valid && on_screen;
    end

    // A surviving box never reaches past the screen
    a_clip_inside: assert property (
        @(posedge clk) disable iff (!arst_n)
        clip_valid |-> ($signed(clip_box.ur_x) <= $signed(screen.width)) &&
                       ($signed(clip_box.ur_y) <= $signed(screen.height))
    );

endmodule

//--- bbox_minmax.sv
// Finds the raw axis-aligned box around a triangle's x and y, combinational
`timescale 1ns/100ps

module bbox_minmax (
    input  logic               clk,
    input  logic               arst_n,
    input  raster_pkg::tri_t   triangle,
    output raster_pkg::box_t   raw_box
);
    import raster_pkg::*;

    // Vertex coordinates as arrays so the search is one loop
    coord_t xs [verts];
    coord_t ys [verts];

    assign xs[0] = triangle.v0.x;
    assign xs[1] = triangle.v1.x;
    assign xs[2] = triangle.v2.x;
    assign ys[0] = triangle.v0.y;
    assign ys[1] = triangle.v1.y;
    assign ys[2] = triangle.v2.y;

    always_comb begin
        coord_t lo_x;
        coord_t lo_y;
        coord_t hi_x;
        coord_t hi_y;
        // Start from vertex 0, then walk the rest
        lo_x = xs[0];
        hi_x = xs[0];
        lo_y = ys[0];
        hi_y = ys[0];
        for (int i = 1; i < verts; i++) begin
            if (xs[i] < lo_x) lo_x = xs[i];
            if (xs[i] > hi_x) hi_x = xs[i];
            if (ys[i] < lo_y) lo_y = ys[i];
            if (ys[i] > hi_y) hi_y = ys[i];
        end
        raw_box.ll_x = lo_x;
        raw_box.ll_y = lo_y;
        raw_box.ur_x = hi_x;
        raw_box.ur_y = hi_y;
    end

    // Degenerate triangles give ll == ur, so the check is not strict
    a_raw_ordered: assert property (
        @(posedge clk) disable iff (!arst_n)
        ($signed(raw_box.ur_x) >= $signed(raw_box.ll_x)) &&
        ($signed(raw_box.ur_y) >= $signed(raw_box.ll_y))
    );

endmodule

//--- bbox_pipe.sv
// Halt-able register chain carrying triangle, colour, box and valid to the output
`timescale 1ns/100ps

module bbox_pipe (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    halt_n,
    input  raster_pkg::bbox_item_t  in_item,
    output raster_pkg::bbox_item_t  out_item
);
    import raster_pkg::*;

    // Stage 0 takes the input, last stage drives the output
    bbox_item_t stage [pipe_depth];

    // Struct layout must match the declared word counts
    if ($bits(bbox_item_t) != item_bits) begin : g_layout_check
        $error("bbox_item_t width does not match item_bits");
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Valid bits cleared, data zeroed with them
            for (int i = 0; i < pipe_depth; i++) begin
                stage[i] <= '0;
            end
        end else if (halt_n) begin
            stage[0] <= in_item;
            // Shift toward the output, all stages together
            for (int i = 1; i < pipe_depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out_item = stage[pipe_depth-1];

    // Flooring and clamping must not have crossed the corners over
    a_out_ordered: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_item.valid |->
            ($signed(out_item.box.ll_x) <= $signed(out_item.box.ur_x)) &&
            ($signed(out_item.box.ll_y) <= $signed(out_item.box.ur_y))
    );

endmodule

//--- bbox_snap.sv
// Floors the raw box corners to the MSAA sample grid, combinational
`timescale 1ns/100ps

module bbox_snap (
    input  logic                clk,
    input  logic                arst_n,
    input  raster_pkg::box_t    raw_box,
    input  raster_pkg::msaa_e   msaa,
    output raster_pkg::box_t    snap_box
);
    import raster_pkg::*;

    // Fraction bits kept from the top of the fraction
    logic [1:0]       keep_bits;
    // One sample side in fixed point
    coord_t           step;
    logic [radix-1:0] step_frac;
    logic [radix-1:0] frac_mask;

    always_comb begin
        unique case (msaa)
            msaa_1x:  keep_bits = 2'd0;
            msaa_4x:  keep_bits = 2'd1;
            msaa_16x: keep_bits = 2'd2;
            msaa_64x: keep_bits = 2'd3;
            default:  keep_bits = 2'd0;
        endcase
    end

    assign step      = coord_t'(1) << (radix - int'(keep_bits));
    assign step_frac = step[radix-1:0];
    // 1x has no step bit in the fraction, so the mask comes out all zero
    assign frac_mask = ~(step_frac - radix'(1));

    // Integer part untouched, fraction masked
    // Two's complement makes this a floor toward minus infinity
    function automatic coord_t floor_coord(coord_t c, logic [radix-1:0] mask);
        return {c[sigfig-1:radix], c[radix-1:0] & mask};
    endfunction

    assign snap_box.ll_x = floor_coord(raw_box.ll_x, frac_mask);
    assign snap_box.ll_y = floor_coord(raw_box.ll_y, frac_mask);
    assign snap_box.ur_x = floor_coord(raw_box.ur_x, frac_mask);
    assign snap_box.ur_y = floor_coord(raw_box.ur_y, frac_mask);

    // Moved down by zero up to just under one sample side
    function automatic logic drop_ok(coord_t orig, coord_t snapped, coord_t side);
        coord_t drop;
        drop = orig - snapped;
        return (drop >= 0) && (drop < side);
    endfunction

    a_snap_floor: assert property (
        @(posedge clk) disable iff (!arst_n)
        drop_ok(raw_box.ll_x, snap_box.ll_x, step) &&
        drop_ok(raw_box.ll_y, snap_box.ll_y, step) &&
        drop_ok(raw_box.ur_x, snap_box.ur_x, step) &&
        drop_ok(raw_box.ur_y, snap_box.ur_y, step)
    );

endmodule

//--- bbox_tb_model.svh
// Reference model for the bbox testbench: expected box rules and a cycle model of the pipeline
`ifndef BBOX_TB_MODEL_SVH
`define BBOX_TB_MODEL_SVH

// Expected items in flight, last entry is what the outputs should show
bbox_item_t model_pipe [pipe_depth];

function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
    coord_t m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
endfunction

function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
    coord_t m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
endfunction

// Floor to a multiple of the sample side, side = one pixel >> log2 of samples per side
function automatic coord_t floor_to_grid(coord_t c, msaa_e m);
    int shift;
    case (m)
        msaa_4x:  shift = radix - 1;
        msaa_16x: shift = radix - 2;
        msaa_64x: shift = radix - 3;
        default:  shift = radix;
    endcase
    return (c >>> shift) <<< shift;
endfunction

function automatic bbox_item_t expected_item(tri_t t, rgb_t col, logic v, screen_t scr,
                                             msaa_e m);
    bbox_item_t item;
    coord_t lx;
    coord_t ly;
    coord_t ux;
    coord_t uy;
    lx = floor_to_grid(min3(t.v0.x, t.v1.x, t.v2.x), m);
    ly = floor_to_grid(min3(t.v0.y, t.v1.y, t.v2.y), m);
    ux = floor_to_grid(max3(t.v0.x, t.v1.x, t.v2.x), m);
    uy = floor_to_grid(max3(t.v0.y, t.v1.y, t.v2.y), m);
    // Clamp to origin and screen size
    if (lx < 0) lx = '0;
    if (ly < 0) ly = '0;
    if (ux > scr.width) ux = scr.width;
    if (uy > scr.height) uy = scr.height;
    item.triangle = t;
    item.color = col;
    item.box = '{ll_x: lx, ll_y: ly, ur_x: ux, ur_y: uy};
    item.valid = v && (lx <= scr.width) && (ux >= 0) && (ly <= scr.height) && (uy >= 0);
    return item;
endfunction

task automatic model_clear();
    for (int i = 0; i < pipe_depth; i++) begin
        model_pipe[i] = '0;
    end
endtask

// One enabled edge: everything moves one stage toward the output
task automatic model_shift(input bbox_item_t item);
    for (int i = pipe_depth - 1; i > 0; i--) begin
        model_pipe[i] = model_pipe[i-1];
    end
    model_pipe[0] = item;
endtask

function automatic logic model_busy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < pipe_depth; i++) begin
        busy = busy | model_pipe[i].valid;
    end
    return busy;
endfunction

`endif

//--- bbox_tb.sv
// Self-checking testbench for the bbox stage, seeded random triangles checked against a cycle model
`timescale 1ns/100ps

module bbox_tb;
    import raster_pkg::*;

    // Screen in whole pixels
    localparam int scr_w_px = 640;
    localparam int scr_h_px = 480;
    // Cycle bound for any single wait
    localparam int wait_limit = 4000;

    logic    clk;
    logic    arst_n;
    tri_t    in_tri;
    rgb_t    in_color;
    logic    in_valid;
    screen_t screen;
    msaa_e   msaa;
    logic    halt_n;
    tri_t    out_tri;
    rgb_t    out_color;
    box_t    out_box;
    logic    out_valid;

    int seed;
    int check_count;
    int error_count;
    int test_count;
    int failed_tests;

    `include "bbox_tb_model.svh"

    bbox DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_tri    (in_tri),
        .in_color  (in_color),
        .in_valid  (in_valid),
        .screen    (screen),
        .msaa      (msaa),
        .halt_n    (halt_n),
        .out_tri   (out_tri),
        .out_color (out_color),
        .out_box   (out_box),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare(input string name, input logic [255:0] got, input logic [255:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        bbox_item_t want;
        want = model_pipe[pipe_depth-1];
        compare("out_valid", 256'(out_valid), 256'(want.valid));
        if (want.valid) begin
            compare("out_box", 256'(out_box), 256'(want.box));
            compare("out_tri", 256'(out_tri), 256'(want.triangle));
            compare("out_color", 256'(out_color), 256'(want.color));
        end
        // Advance by what the next rising edge will capture
        if (!arst_n) begin
            model_clear();
        end else if (halt_n) begin
            model_shift(expected_item(in_tri, in_color, in_valid, screen, msaa));
        end
    end

    // Random fixed point between two whole-pixel bounds, fraction included
    function automatic coord_t rand_coord(int lo_px, int hi_px);
        int span;
        int r;
        span = (hi_px - lo_px) * (1 << radix) + 1;
        r = int'($unsigned($random(seed)) % span);
        return coord_t'(lo_px * (1 << radix) + r);
    endfunction

    // place 0 on screen, 1 with half a screen of margin, 2 also wholly off one side
    task automatic make_triangle(input int place, output tri_t t);
        vertex_t vs [verts];
        int lo_x;
        int hi_x;
        int lo_y;
        int hi_y;
        int side;
        lo_x = 0;
        hi_x = scr_w_px;
        lo_y = 0;
        hi_y = scr_h_px;
        if (place >= 1) begin
            lo_x = -scr_w_px / 2;
            hi_x = scr_w_px * 3 / 2;
            lo_y = -scr_h_px / 2;
            hi_y = scr_h_px * 3 / 2;
        end
        side = (place == 2) ? int'($unsigned($random(seed)) % 5) : 4;
        case (side)
            0: lo_x = scr_w_px + 1;
            1: hi_x = -1;
            2: lo_y = scr_h_px + 1;
            3: hi_y = -1;
            default: lo_x = lo_x;
        endcase
        // Off-screen bands stay within 200 pixels of the edge
        if (side == 0) hi_x = scr_w_px + 200;
        if (side == 1) lo_x = -200;
        if (side == 2) hi_y = scr_h_px + 200;
        if (side == 3) lo_y = -200;
        for (int i = 0; i < verts; i++) begin
            vs[i].x = rand_coord(lo_x, hi_x);
            vs[i].y = rand_coord(lo_y, hi_y);
            vs[i].z = coord_t'($random(seed));
        end
        t = '{v0: vs[0], v1: vs[1], v2: vs[2]};
    endtask

    task automatic report_test(input string name, input int errors_before);
        int errs;
        errs = error_count - errors_before;
        test_count++;
        if (errs != 0) failed_tests++;
        $display("Test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    task automatic drain_pipe(input string name);
        int waited;
        logic taken;
        taken = 1'b0;
        waited = 0;
        // Last driven input still has to be taken
        while (!taken && waited < wait_limit) begin
            @(posedge clk);
            taken = halt_n;
            halt_n <= 1'b1;
            waited++;
        end
        in_valid <= 1'b0;
        waited = 0;
        while (model_busy() && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (model_busy() || !taken) begin
            error_count++;
            $display("Timeout: pipeline did not drain after %s", name);
        end
    endtask

    // One valid triangle must show up after exactly pipe_depth enabled edges
    task automatic test_latency();
        tri_t t;
        int edges;
        int errors_before;
        logic seen;
        errors_before = error_count;
        @(posedge clk);
        make_triangle(0, t);
        in_tri <= t;
        in_valid <= 1'b1;
        edges = 0;
        seen = 1'b0;
        while (!seen && edges < wait_limit) begin
            @(posedge clk);
            edges++;
            in_valid <= 1'b0;
            @(negedge clk);
            seen = out_valid;
        end
        if (!seen) begin
            error_count++;
            $display("Timeout: valid triangle never reached the output");
        end
        compare("latency", 256'(edges), 256'(pipe_depth));
        drain_pipe("latency");
        report_test("reset_latency", errors_before);
    endtask

    task automatic run_phase(input string name, input msaa_e mode, input int place,
                             input logic use_halt, input int count);
        tri_t t;
        int sent;
        int cycles;
        int errors_before;
        errors_before = error_count;
        // Pipeline is empty here, so the mode may change
        @(posedge clk);
        msaa <= mode;
        sent = 0;
        cycles = 0;
        while (sent < count && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
            // Previous input taken at this edge, next one may go out
            if (halt_n) begin
                make_triangle(place, t);
                in_tri <= t;
                in_color <= '{r: color_t'($random(seed)), g: color_t'($random(seed)),
                              b: color_t'($random(seed))};
                in_valid <= (place == 2) ? (($unsigned($random(seed)) % 4) != 0) : 1'b1;
                sent++;
            end
            halt_n <= use_halt ? (($unsigned($random(seed)) % 3) != 0) : 1'b1;
        end
        if (sent < count) begin
            error_count++;
            $display("Timeout: %s sent only %0d of %0d triangles", name, sent, count);
        end
        drain_pipe(name);
        report_test(name, errors_before);
    endtask

    initial begin
        seed = 26;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        arst_n = 1'b0;
        halt_n = 1'b1;
        in_valid = 1'b0;
        in_tri = '0;
        in_color = '0;
        msaa = msaa_1x;
        screen = '{width: coord_t'(scr_w_px << radix), height: coord_t'(scr_h_px << radix)};
        model_clear();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        test_latency();
        run_phase("onscreen_1x", msaa_1x, 0, 1'b0, 200);
        run_phase("snap_4x", msaa_4x, 0, 1'b0, 150);
        run_phase("snap_16x", msaa_16x, 0, 1'b0, 150);
        run_phase("snap_64x", msaa_64x, 0, 1'b0, 150);
        run_phase("clamp_partial", msaa_16x, 1, 1'b0, 200);
        run_phase("reject_offscreen", msaa_4x, 2, 1'b0, 200);
        run_phase("halt_random", msaa_64x, 2, 1'b1, 300);
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- raster_pkg.sv
// Shared fixed-point widths, MSAA codes and pipeline item types, imported by every bbox file
package raster_pkg;

    // Word width of a coordinate or a colour channel
    localparam int sigfig = 24;
    // Fraction bits of a fixed-point coordinate
    localparam int radix = 10;
    // Vertices in one triangle
    localparam int verts = 3;
    // Colour channels carried with a triangle
    localparam int colors = 3;
    // Enabled edges from accepted input to output
    localparam int pipe_depth = 3;

    // Bits in one pipeline item
    // xyz per vertex, colour, four box corners, valid
    localparam int item_bits = sigfig * (verts * 3 + colors + 4) + 1;

    // Signed fixed point, integer part above radix
    typedef logic signed [sigfig-1:0] coord_t;

    // Unsigned colour channel
    typedef logic [sigfig-1:0] color_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        // Depth rides along, never used for the box
        coord_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } tri_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        coord_t ll_x;
        coord_t ll_y;
        coord_t ur_x;
        coord_t ur_y;
    } box_t;

    // Visible area, origin at zero
    typedef struct packed {
        coord_t width;
        coord_t height;
    } screen_t;

    // One-hot sample grid select
    // 1x whole pixel, 4x half, 16x quarter, 64x eighth
    typedef enum logic [3:0] {
        msaa_1x  = 4'b1000,
        msaa_4x  = 4'b0100,
        msaa_16x = 4'b0010,
        msaa_64x = 4'b0001
    } msaa_e;

    // Unit that moves through the pipeline
    typedef struct packed {
        tri_t   triangle;
        rgb_t   color;
        box_t   box;
        // Triangle present and box on screen
        logic   valid;
    } bbox_item_t;

endpackage
